//--- hdl/i2c_pkg.sv
package i2c_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  reg_addr_t;
    typedef logic [15:0] prescale_t;

    localparam reg_addr_t ADDR_FDR   = 3'd1;
    localparam reg_addr_t ADDR_CR    = 3'd2;
    localparam reg_addr_t ADDR_SR    = 3'd3;
    localparam reg_addr_t ADDR_DR    = 3'd4;
    localparam reg_addr_t ADDR_DFSRR = 3'd5;

    localparam int CCR_MEN  = 7;
    localparam int CCR_MSTA = 5;
    localparam int CCR_MTX  = 4;
    localparam int CCR_TXAK = 3;

    localparam int CSR_MCF  = 7;
    localparam int CSR_MBB  = 5;
    localparam int CSR_MIF  = 1;
    localparam int CSR_RXAK = 0;

    localparam byte_t     SR_RESET       = 8'h81;
    localparam byte_t     DFSRR_RESET    = 8'h10;
    localparam prescale_t PRESCALE_RESET = 16'd384;
    localparam prescale_t SAMPLE_RESET   = 16'd24;   // 384 / 16

    typedef enum logic [2:0] {
        CMD_IDLE,
        CMD_START,
        CMD_WRITE,
        CMD_READ,
        CMD_STOP
    } i2c_cmd_e;

    // scl period in sysclk cycles for each fdr code
    function automatic prescale_t freq_div_get(input byte_t fdr);
        case (fdr[5:0])
            6'h00: return 16'd384;
            6'h01: return 16'd416;
            6'h02: return 16'd480;
            6'h03: return 16'd576;
            6'h04: return 16'd640;
            6'h05: return 16'd704;
            6'h06: return 16'd832;
            6'h07: return 16'd1024;
            6'h08: return 16'd1152;
            6'h09: return 16'd1280;
            6'h0A: return 16'd1536;
            6'h0B: return 16'd1920;
            6'h0C: return 16'd2304;
            6'h0D: return 16'd2560;
            6'h0E: return 16'd3072;
            6'h0F: return 16'd3840;
            6'h10: return 16'd4608;
            6'h11: return 16'd5120;
            6'h12: return 16'd6144;
            6'h13: return 16'd7680;
            6'h14: return 16'd9216;
            6'h15: return 16'd10240;
            6'h16: return 16'd12288;
            6'h17: return 16'd15360;
            6'h18: return 16'd18432;
            6'h19: return 16'd20480;
            6'h1A: return 16'd24576;
            6'h1B: return 16'd30720;
            6'h1C: return 16'd36864;
            6'h1D: return 16'd40960;
            6'h1E: return 16'd49152;
            6'h1F: return 16'd61440;
            6'h20: return 16'd256;
            6'h21: return 16'd288;
            6'h22: return 16'd320;
            6'h23: return 16'd352;
            6'h24: return 16'd384;
            6'h25: return 16'd448;
            6'h26: return 16'd512;
            6'h27: return 16'd576;
            6'h28: return 16'd640;
            6'h29: return 16'd768;
            6'h2A: return 16'd896;
            6'h2B: return 16'd1024;
            6'h2C: return 16'd1280;
            6'h2D: return 16'd1536;
            6'h2E: return 16'd1792;
            6'h2F: return 16'd2048;
            6'h30: return 16'd2560;
            6'h31: return 16'd3072;
            6'h32: return 16'd3584;
            6'h33: return 16'd4096;
            6'h34: return 16'd5120;
            6'h35: return 16'd6144;
            6'h36: return 16'd7168;
            6'h37: return 16'd8192;
            6'h38: return 16'd10240;
            6'h39: return 16'd12288;
            6'h3A: return 16'd14336;
            6'h3B: return 16'd16384;
            6'h3C: return 16'd20480;
            6'h3D: return 16'd24576;
            6'h3E: return 16'd28672;
            default: return 16'd32768;
        endcase
    endfunction

endpackage

//--- hdl/i2c_cmd_if.sv
`timescale 1ns/1ps

interface i2c_cmd_if;
    import i2c_pkg::*;

    logic     req;
    i2c_cmd_e cmd;
    byte_t    wdata;
    logic     tx_nack;   // ack bit sent after a read byte
    logic     ack;
    byte_t    rdata;
    logic     rxack;     // sda sampled in the ninth clock

    modport seq (output req, cmd, wdata, tx_nack, input ack, rdata, rxack);
    modport eng (input req, cmd, wdata, tx_nack, output ack, rdata, rxack);

endinterface

//--- hdl/i2c_regs.sv
`timescale 1ns/1ps

module i2c_regs (
    input  logic           sysclk_i,
    input  logic           reset_n_i,
    input  logic           wr_ena_i,
    input  logic [4:0]     wr_addr_i,
    input  i2c_pkg::byte_t wr_data_i,
    input  logic           rd_ena_i,
    input  logic [4:0]     rd_addr_i,
    input  logic           done_i,
    input  logic           rxack_i,
    input  i2c_pkg::byte_t rdata_i,
    input  logic           busy_i,
    output i2c_pkg::byte_t rd_data_o,
    output logic           data_ready_o,
    output i2c_pkg::byte_t fdr_o,
    output i2c_pkg::byte_t dfsrr_o,
    output logic           men_o,
    output logic           mtx_o,
    output logic           txak_o,
    output i2c_pkg::byte_t dr_o,
    output logic           start_o,
    output logic           stop_o,
    output logic           write_o,
    output logic           read_o
);
    import i2c_pkg::*;

    byte_t     cr_q;
    byte_t     sr_q;
    reg_addr_t wsel;
    reg_addr_t rsel;
    logic      xfer_q;   // byte write or read in flight
    logic      msta_up;
    logic      msta_down;
    logic      dr_take;

    assign wsel         = wr_addr_i[4:2];
    assign rsel         = rd_addr_i[4:2];
    assign men_o        = cr_q[CCR_MEN];
    assign mtx_o        = cr_q[CCR_MTX];
    assign txak_o       = cr_q[CCR_TXAK];
    assign data_ready_o = sr_q[CSR_MCF];
    assign msta_up      = wr_data_i[CCR_MSTA] & ~cr_q[CCR_MSTA] & wr_data_i[CCR_MEN];
    assign msta_down    = ~wr_data_i[CCR_MSTA] & cr_q[CCR_MSTA];
    assign dr_take      = wr_ena_i && (wsel == ADDR_DR) && sr_q[CSR_MBB]
                          && sr_q[CSR_MCF] && !sr_q[CSR_MIF];

    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            fdr_o     <= '0;
            cr_q      <= '0;
            dfsrr_o   <= DFSRR_RESET;
            sr_q      <= SR_RESET;
            rd_data_o <= 8'hFF;
            xfer_q    <= 1'b0;
            start_o   <= 1'b0;
            stop_o    <= 1'b0;
            write_o   <= 1'b0;
            read_o    <= 1'b0;
        end
        else
        begin
            start_o <= 1'b0;
            stop_o  <= 1'b0;
            write_o <= 1'b0;
            read_o  <= 1'b0;
            if (done_i)
            begin
                sr_q[CSR_MCF] <= 1'b1;
                sr_q[CSR_MBB] <= busy_i;
                xfer_q        <= 1'b0;
                if (xfer_q)
                begin
                    sr_q[CSR_MIF]  <= 1'b1;
                    sr_q[CSR_RXAK] <= rxack_i;
                    rd_data_o      <= rdata_i;
                end
            end
            if (wr_ena_i)
            begin
                case (wsel)
                    ADDR_FDR:   fdr_o <= wr_data_i;
                    ADDR_CR:
                    begin
                        cr_q <= wr_data_i;
                        if (sr_q[CSR_MCF] && (msta_up || msta_down))
                        begin
                            sr_q[CSR_MCF] <= 1'b0;
                            start_o       <= msta_up;
                            stop_o        <= msta_down;
                        end
                    end
                    ADDR_SR:    if (!wr_data_i[CSR_MIF]) sr_q[CSR_MIF] <= 1'b0;
                    ADDR_DFSRR: dfsrr_o <= wr_data_i;
                    default:
                    begin
                        if (dr_take)
                        begin
                            sr_q[CSR_MCF] <= 1'b0;
                            write_o       <= 1'b1;
                            xfer_q        <= 1'b1;
                        end
                    end
                endcase
            end
            if (rd_ena_i)
            begin
                case (rsel)
                    ADDR_FDR:   rd_data_o <= fdr_o;
                    ADDR_CR:    rd_data_o <= cr_q;
                    ADDR_DFSRR: rd_data_o <= dfsrr_o;
                    ADDR_DR:
                    begin
                        if (sr_q[CSR_MBB] && sr_q[CSR_MCF])   // result lands at done
                        begin
                            sr_q[CSR_MCF] <= 1'b0;
                            read_o        <= 1'b1;
                            xfer_q        <= 1'b1;
                        end
                    end
                    default:    rd_data_o <= sr_q;
                endcase
            end
        end
    end

    always_ff @(posedge sysclk_i)
    begin
        if (dr_take)
            dr_o <= wr_data_i;
    end

endmodule

//--- hdl/i2c_cmd_seq.sv
`timescale 1ns/1ps

module i2c_cmd_seq (
    input  logic           sysclk_i,
    input  logic           reset_n_i,
    input  logic           start_i,
    input  logic           stop_i,
    input  logic           write_i,
    input  logic           read_i,
    input  logic           men_i,
    input  logic           mtx_i,
    input  logic           txak_i,
    input  i2c_pkg::byte_t dr_i,
    output logic           done_o,
    output logic           rxack_o,
    output i2c_pkg::byte_t rdata_o,
    output logic           busy_o,
    i2c_cmd_if.seq         cmd
);
    import i2c_pkg::*;

    typedef enum logic [2:0] {IDLE, START, WRITE, READ, STOP, WAIT_ACK_LOW} seq_state_e;

    seq_state_e state;
    logic       trig;
    logic       reject;

    assign trig   = start_i | stop_i | write_i | read_i;
    assign reject = !men_i || (write_i && !mtx_i) || (read_i && mtx_i);

    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            state       <= IDLE;
            cmd.req     <= 1'b0;
            cmd.cmd     <= CMD_IDLE;
            cmd.tx_nack <= 1'b0;
            done_o      <= 1'b0;
            busy_o      <= 1'b0;
            rxack_o     <= 1'b1;
        end
        else
        begin
            done_o <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (trig && reject)
                        done_o <= 1'b1;   // complete at once, bus untouched
                    else if (trig)
                    begin
                        cmd.req <= 1'b1;
                        if (start_i)
                        begin
                            cmd.cmd <= CMD_START;
                            state   <= START;
                        end
                        else if (stop_i)
                        begin
                            cmd.cmd <= CMD_STOP;
                            state   <= STOP;
                        end
                        else if (write_i)
                        begin
                            cmd.cmd <= CMD_WRITE;
                            state   <= WRITE;
                        end
                        else
                        begin
                            cmd.cmd     <= CMD_READ;
                            cmd.tx_nack <= txak_i;
                            state       <= READ;
                        end
                    end
                end
                START, WRITE, READ, STOP:
                begin
                    if (cmd.ack)
                    begin
                        cmd.req <= 1'b0;
                        if (state == WRITE || state == READ)
                            rxack_o <= cmd.rxack;
                        state <= WAIT_ACK_LOW;
                    end
                end
                default:
                begin
                    if (!cmd.ack)
                    begin
                        done_o <= 1'b1;
                        if (cmd.cmd == CMD_START)
                            busy_o <= 1'b1;
                        else if (cmd.cmd == CMD_STOP)
                            busy_o <= 1'b0;
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sysclk_i)
    begin
        if (state == IDLE && write_i)
            cmd.wdata <= dr_i;
        if ((state == WRITE || state == READ) && cmd.ack)
            rdata_o <= cmd.rdata;
    end

endmodule

//--- hdl/i2c_rate_div.sv
`timescale 1ns/1ps

module i2c_rate_div (
    input  logic               sysclk_i,
    input  logic               reset_n_i,
    input  i2c_pkg::byte_t     fdr_i,
    input  i2c_pkg::byte_t     dfsrr_i,
    output i2c_pkg::prescale_t prescale_o,
    output i2c_pkg::prescale_t sample_o
);
    import i2c_pkg::*;

    typedef enum logic [1:0] {DV_LOAD, DV_SUB, DV_SHIFT, DV_DONE} div_state_e;

    div_state_e  state;
    logic [4:0]  cnt;
    logic [31:0] rem_q;   // running dividend
    logic [31:0] den_q;   // divisor aligned to the upper half
    prescale_t   quo_q;
    logic        vld;

    assign vld = (state == DV_DONE);

    // load + 17 sub + 16 shift + done = 35 cycles
    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            state      <= DV_LOAD;
            cnt        <= '0;
            prescale_o <= PRESCALE_RESET;
            sample_o   <= SAMPLE_RESET;
        end
        else
        begin
            prescale_o <= freq_div_get(fdr_i);
            if (vld)
                sample_o <= quo_q;
            case (state)
                DV_LOAD:  state <= DV_SUB;
                DV_SUB:   state <= (cnt == 5'd16) ? DV_DONE : DV_SHIFT;
                DV_SHIFT: state <= DV_SUB;
                default:  state <= DV_LOAD;
            endcase
            if (state == DV_LOAD)
                cnt <= '0;
            else if (state == DV_SHIFT)
                cnt <= cnt + 5'd1;
        end
    end

    always_ff @(posedge sysclk_i)
    begin
        case (state)
            DV_LOAD:
            begin
                rem_q <= {16'h0000, prescale_o};
                den_q <= {10'h000, dfsrr_i[5:0], 16'h0000};
            end
            DV_SUB:
            begin
                if (rem_q >= den_q)
                begin
                    rem_q <= rem_q - den_q;
                    quo_q <= {quo_q[14:0], 1'b1};
                end
                else
                    quo_q <= {quo_q[14:0], 1'b0};
            end
            DV_SHIFT: rem_q <= rem_q << 1;
            default:  ;
        endcase
    end

endmodule

//--- hdl/i2c_byte_engine.sv
`timescale 1ns/1ps

module i2c_byte_engine (
    input  logic               sysclk_i,
    input  logic               reset_n_i,
    input  i2c_pkg::prescale_t prescale_i,
    input  i2c_pkg::prescale_t sample_i,
    input  logic               scl_i,
    input  logic               sda_i,
    output logic               scl_oen_o,
    output logic               sda_oen_o,
    i2c_cmd_if.eng             cmd
);
    import i2c_pkg::*;

    typedef enum logic [2:0] {ST_IDLE, ST_START, ST_STOP, ST_WRITE, ST_READ, ST_DONE} eng_state_e;

    eng_state_e state;
    prescale_t  smp_cnt;
    prescale_t  smp_per;
    logic [2:0] scl_taps;
    logic [2:0] sda_taps;
    logic       scl_f;
    logic       sda_f;
    prescale_t  tmr;
    prescale_t  qtr;
    prescale_t  half;
    prescale_t  qtr3;
    logic       tmr_end;
    logic       stall;
    logic       sda_next;
    logic [3:0] bit_cnt;
    byte_t      shreg;

    function automatic logic maj3(input logic [2:0] v);
        return (v[0] & v[1]) | (v[0] & v[2]) | (v[1] & v[2]);
    endfunction

    assign smp_per   = (sample_i == '0) ? 16'd1 : sample_i;
    assign scl_f     = maj3(scl_taps);
    assign sda_f     = maj3(sda_taps);
    assign qtr       = prescale_i >> 2;
    assign half      = prescale_i >> 1;
    assign qtr3      = qtr + half;
    assign tmr_end   = (tmr == prescale_i - 16'd1);
    assign stall     = tmr_end && !scl_oen_o && !scl_f;   // slave stretching scl
    assign cmd.rdata = shreg;

    always_comb
    begin
        case (state)
            ST_WRITE: sda_next = (bit_cnt < 4'd8) ? ~shreg[7] : 1'b0;
            ST_READ:  sda_next = (bit_cnt < 4'd8) ? 1'b0 : ~cmd.tx_nack;
            default:  sda_next = 1'b1;   // start and stop pull sda first
        endcase
    end

    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            smp_cnt  <= '0;
            scl_taps <= 3'b111;
            sda_taps <= 3'b111;
        end
        else if (smp_cnt == '0)
        begin
            smp_cnt  <= smp_per - 16'd1;
            scl_taps <= {scl_taps[1:0], scl_i};
            sda_taps <= {sda_taps[1:0], sda_i};
        end
        else
            smp_cnt <= smp_cnt - 16'd1;
    end

    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            state     <= ST_IDLE;
            tmr       <= '0;
            bit_cnt   <= '0;
            scl_oen_o <= 1'b0;
            sda_oen_o <= 1'b0;
            cmd.ack   <= 1'b0;
            cmd.rxack <= 1'b1;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    tmr     <= '0;
                    bit_cnt <= '0;
                    if (cmd.req && !cmd.ack)
                    begin
                        case (cmd.cmd)
                            CMD_START: state <= ST_START;
                            CMD_STOP:  state <= ST_STOP;
                            CMD_WRITE: state <= ST_WRITE;
                            CMD_READ:  state <= ST_READ;
                            default:
                            begin
                                state   <= ST_DONE;
                                cmd.ack <= 1'b1;
                            end
                        endcase
                    end
                end
                ST_DONE:
                begin
                    if (!cmd.req)
                    begin
                        cmd.ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default:
                begin
                    if (!stall)
                        tmr <= tmr_end ? '0 : tmr + 16'd1;
                    if (tmr == '0)
                        scl_oen_o <= (state != ST_START);
                    if (tmr == qtr)
                        sda_oen_o <= sda_next;
                    if (tmr == half)
                        scl_oen_o <= 1'b0;
                    if (tmr == qtr3 && state == ST_STOP)
                        sda_oen_o <= 1'b0;   // sda rises with scl high
                    if (tmr_end && !stall)
                    begin
                        if ((state == ST_WRITE || state == ST_READ) && bit_cnt != 4'd8)
                            bit_cnt <= bit_cnt + 4'd1;
                        else
                        begin
                            if (state == ST_WRITE || state == ST_READ)
                                cmd.rxack <= sda_f;
                            state   <= ST_DONE;
                            cmd.ack <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // msb first, sampled bits enter at the bottom
    always_ff @(posedge sysclk_i)
    begin
        if (state == ST_IDLE)
            shreg <= cmd.wdata;
        else if ((state == ST_WRITE || state == ST_READ) && tmr_end && !stall
                 && bit_cnt < 4'd8)
            shreg <= {shreg[6:0], sda_f};
    end

endmodule

//--- hdl/i2c_master_top.sv
`timescale 1ns/1ps

module i2c_master_top (
    input  logic           sysclk_i,
    input  logic           reset_n_i,
    input  logic           wr_ena_i,
    input  logic [4:0]     wr_addr_i,
    input  i2c_pkg::byte_t wr_data_i,
    input  logic           rd_ena_i,
    input  logic [4:0]     rd_addr_i,
    output i2c_pkg::byte_t rd_data_o,
    output logic           data_ready_o,
    input  logic           scl_i,
    input  logic           sda_i,
    output logic           scl_oen_o,
    output logic           sda_oen_o
);
    import i2c_pkg::*;

    byte_t     fdr;
    byte_t     dfsrr;
    byte_t     dr;
    byte_t     rdata;
    prescale_t prescale;
    prescale_t sample;
    logic      men;
    logic      mtx;
    logic      txak;
    logic      start;
    logic      stop;
    logic      write;
    logic      read;
    logic      done;
    logic      rxack;
    logic      busy;

    i2c_cmd_if cmd_bus ();

    i2c_regs u_regs (
        .sysclk_i     (sysclk_i),
        .reset_n_i    (reset_n_i),
        .wr_ena_i     (wr_ena_i),
        .wr_addr_i    (wr_addr_i),
        .wr_data_i    (wr_data_i),
        .rd_ena_i     (rd_ena_i),
        .rd_addr_i    (rd_addr_i),
        .done_i       (done),
        .rxack_i      (rxack),
        .rdata_i      (rdata),
        .busy_i       (busy),
        .rd_data_o    (rd_data_o),
        .data_ready_o (data_ready_o),
        .fdr_o        (fdr),
        .dfsrr_o      (dfsrr),
        .men_o        (men),
        .mtx_o        (mtx),
        .txak_o       (txak),
        .dr_o         (dr),
        .start_o      (start),
        .stop_o       (stop),
        .write_o      (write),
        .read_o       (read)
    );

    i2c_cmd_seq u_seq (
        .sysclk_i  (sysclk_i),
        .reset_n_i (reset_n_i),
        .start_i   (start),
        .stop_i    (stop),
        .write_i   (write),
        .read_i    (read),
        .men_i     (men),
        .mtx_i     (mtx),
        .txak_i    (txak),
        .dr_i      (dr),
        .done_o    (done),
        .rxack_o   (rxack),
        .rdata_o   (rdata),
        .busy_o    (busy),
        .cmd       (cmd_bus.seq)
    );

    i2c_rate_div u_rate (
        .sysclk_i   (sysclk_i),
        .reset_n_i  (reset_n_i),
        .fdr_i      (fdr),
        .dfsrr_i    (dfsrr),
        .prescale_o (prescale),
        .sample_o   (sample)
    );

    i2c_byte_engine u_engine (
        .sysclk_i   (sysclk_i),
        .reset_n_i  (reset_n_i),
        .prescale_i (prescale),
        .sample_i   (sample),
        .scl_i      (scl_i),
        .sda_i      (sda_i),
        .scl_oen_o  (scl_oen_o),
        .sda_oen_o  (sda_oen_o),
        .cmd        (cmd_bus.eng)
    );

endmodule

//--- testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic sysclk_o,
    output logic reset_n_o
);

    initial
    begin
        sysclk_o = 1'b0;
        forever #10 sysclk_o = ~sysclk_o;   // 20 ns period
    end

    initial
    begin
        reset_n_o = 1'b0;
        repeat (16) @(posedge sysclk_o);
        reset_n_o <= 1'b1;
    end

endmodule

//--- testbench/tb_i2c_slave.sv
`timescale 1ns/1ps

module tb_i2c_slave (
    input  logic           scl_i,
    input  logic           sda_i,
    input  logic           read_mode_i,
    output logic           sda_low_o,
    output int             start_cnt_o,
    output int             stop_cnt_o,
    output i2c_pkg::byte_t rx_byte_o,
    output logic           mack_o
);
    import i2c_pkg::*;

    logic  scl_q   = 1'b1;
    logic  sda_q   = 1'b1;
    logic  sda_low = 1'b0;
    int    starts  = 0;
    int    stops   = 0;
    int    bit_cnt = 0;       // 8 is the ack slot
    byte_t shreg   = 8'h00;
    byte_t txsh    = 8'h00;
    byte_t last_wr = 8'h00;
    byte_t rx_byte = 8'h00;
    logic  mack    = 1'b1;

    assign sda_low_o   = sda_low;
    assign start_cnt_o = starts;
    assign stop_cnt_o  = stops;
    assign rx_byte_o   = rx_byte;
    assign mack_o      = mack;

    always @(posedge scl_i or negedge scl_i or posedge sda_i or negedge sda_i)
    begin
        if (scl_i !== scl_q && scl_i === 1'b1)
        begin
            if (bit_cnt < 8)
                shreg = {shreg[6:0], sda_i};
            else if (read_mode_i)
                mack = sda_i;   // master ack bit
            bit_cnt = (bit_cnt == 8) ? 0 : bit_cnt + 1;
        end
        else if (scl_i !== scl_q)
        begin
            sda_low = 1'b0;
            if (read_mode_i && bit_cnt < 8)
            begin
                if (bit_cnt == 0)
                    txsh = ~last_wr;   // reads return the inverted last write
                sda_low = ~txsh[7];
                txsh    = {txsh[6:0], 1'b0};
            end
            else if (!read_mode_i && bit_cnt == 8)
            begin
                rx_byte = shreg;
                last_wr = shreg;
                sda_low = ~shreg[7];   // ack only bytes with msb clear
            end
        end
        else if (scl_i === 1'b1 && sda_i === 1'b0 && sda_q === 1'b1)
        begin
            starts  = starts + 1;
            bit_cnt = 0;
        end
        else if (scl_i === 1'b1 && sda_i === 1'b1 && sda_q === 1'b0)
            stops = stops + 1;
        scl_q = scl_i;
        sda_q = sda_i;
    end

endmodule

//--- testbench/tb_i2c_master.sv
`timescale 1ns/1ps

module tb_i2c_master;
    import i2c_pkg::*;

    typedef enum logic [1:0] {OP_START, OP_WRITE, OP_READ, OP_STOP} op_e;

    typedef struct {
        op_e         kind;
        byte_t       fdr;
        byte_t       data;
        logic        txak;
        logic        exp_rxack;
        byte_t       exp_rd;
        int unsigned exp_period;
    } row_t;

    localparam int WAIT_LIMIT = 20000;

    logic        sysclk;
    logic        reset_n;
    logic        wr_ena;
    logic [4:0]  wr_addr;
    byte_t       wr_data;
    logic        rd_ena;
    logic [4:0]  rd_addr;
    byte_t       rd_data;
    logic        data_ready;
    logic        scl_oen;
    logic        sda_oen;
    logic        slave_low;
    logic        scl;
    logic        sda;
    logic        read_mode;
    int          starts;
    int          stops;
    byte_t       slave_byte;
    logic        slave_mack;
    int unsigned cyc        = 0;
    int unsigned rise_at    = 0;
    int unsigned scl_period = 0;
    logic        scl_q      = 1'b1;
    row_t        rows[$];
    byte_t       last_wr    = 8'h00;

    assign scl = ~scl_oen;   // wired-and, slave never stretches
    assign sda = ~(sda_oen | slave_low);

    tb_clkgen u_clk (
        .sysclk_o  (sysclk),
        .reset_n_o (reset_n)
    );

    i2c_master_top uut (
        .sysclk_i     (sysclk),
        .reset_n_i    (reset_n),
        .wr_ena_i     (wr_ena),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (wr_data),
        .rd_ena_i     (rd_ena),
        .rd_addr_i    (rd_addr),
        .rd_data_o    (rd_data),
        .data_ready_o (data_ready),
        .scl_i        (scl),
        .sda_i        (sda),
        .scl_oen_o    (scl_oen),
        .sda_oen_o    (sda_oen)
    );

    tb_i2c_slave u_slave (
        .scl_i       (scl),
        .sda_i       (sda),
        .read_mode_i (read_mode),
        .sda_low_o   (slave_low),
        .start_cnt_o (starts),
        .stop_cnt_o  (stops),
        .rx_byte_o   (slave_byte),
        .mack_o      (slave_mack)
    );

    // scl rise to rise in sysclk cycles
    always @(posedge sysclk)
    begin
        cyc   <= cyc + 1;
        scl_q <= scl;
        if (scl && !scl_q)
        begin
            scl_period <= cyc - rise_at;
            rise_at    <= cyc;
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            stop_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic reg_write(input reg_addr_t sel, input byte_t value);
        @(posedge sysclk);
        wr_ena  <= 1'b1;
        wr_addr <= {sel, 2'b00};
        wr_data <= value;
        @(posedge sysclk);
        wr_ena  <= 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t sel, output byte_t value);
        @(posedge sysclk);
        rd_ena  <= 1'b1;
        rd_addr <= {sel, 2'b00};
        @(posedge sysclk);
        rd_ena  <= 1'b0;
        @(negedge sysclk);
        value = rd_data;   // registered one cycle after rd_ena
    endtask

    task automatic write_readback(input reg_addr_t sel, input byte_t value, input string name);
        byte_t v;
        reg_write(sel, value);
        reg_read(sel, v);
        check_eq(name, 32'(v), 32'(value));
    endtask

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        @(negedge sysclk);
        while (!data_ready && n < WAIT_LIMIT)
        begin
            @(negedge sysclk);
            n++;
        end
        if (!data_ready)
            stop_run($sformatf("timed out waiting for data_ready after %s", what));
    endtask

    function automatic byte_t cr_value(input logic msta, input logic mtx, input logic txak);
        byte_t v;
        v = 8'h00;
        v[CCR_MEN]  = 1'b1;
        v[CCR_MSTA] = msta;
        v[CCR_MTX]  = mtx;
        v[CCR_TXAK] = txak;
        return v;
    endfunction

    // divider table entries for the fdr codes in use
    function automatic int unsigned scl_cycles(input byte_t fdr);
        case (fdr)
            8'h00:   return 384;
            8'h20:   return 256;
            default: return 0;
        endcase
    endfunction

    task automatic add_row(input op_e kind, input byte_t fdr, input byte_t data, input logic txak);
        row_t r;
        r.kind       = kind;
        r.fdr        = fdr;
        r.data       = data;
        r.txak       = txak;
        r.exp_rxack  = data[7];   // nack when msb set
        r.exp_rd     = ~last_wr;
        r.exp_period = scl_cycles(fdr);
        if (kind == OP_WRITE)
            last_wr = data;
        rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        byte_t v;
        int    s0;
        reg_write(ADDR_FDR, r.fdr);
        case (r.kind)
            OP_START:
            begin
                s0 = starts;
                reg_write(ADDR_CR, cr_value(1'b1, 1'b1, 1'b0));
                wait_ready("start");
                check_eq("slave start count", starts, s0 + 1);
                reg_read(ADDR_SR, v);
                check_eq("sr mbb", 32'(v[CSR_MBB]), 32'h1);
                check_eq("sr mcf", 32'(v[CSR_MCF]), 32'h1);
            end
            OP_WRITE:
            begin
                read_mode <= 1'b0;
                reg_write(ADDR_CR, cr_value(1'b1, 1'b1, 1'b0));
                reg_write(ADDR_DR, r.data);
                wait_ready("byte write");
                check_eq("slave rx byte", 32'(slave_byte), 32'(r.data));
                check_eq("scl period", scl_period, r.exp_period);
                reg_read(ADDR_SR, v);
                check_eq("sr rxak", 32'(v[CSR_RXAK]), 32'(r.exp_rxack));
                check_eq("sr mif", 32'(v[CSR_MIF]), 32'h1);
                reg_write(ADDR_SR, 8'h00);
                reg_read(ADDR_SR, v);
                check_eq("sr mif after clear", 32'(v[CSR_MIF]), 32'h0);
            end
            OP_READ:
            begin
                read_mode <= 1'b1;
                reg_write(ADDR_CR, cr_value(1'b1, 1'b0, r.txak));
                reg_read(ADDR_DR, v);   // starts the byte read
                wait_ready("byte read");
                check_eq("rd_data_o", 32'(rd_data), 32'(r.exp_rd));
                check_eq("master ack bit", 32'(slave_mack), 32'(r.txak));
                check_eq("scl period", scl_period, r.exp_period);
                reg_write(ADDR_SR, 8'h00);
            end
            OP_STOP:
            begin
                read_mode <= 1'b0;
                s0 = stops;
                reg_write(ADDR_CR, cr_value(1'b0, 1'b1, 1'b0));
                wait_ready("stop");
                check_eq("slave stop count", stops, s0 + 1);
                reg_read(ADDR_SR, v);
                check_eq("sr mbb", 32'(v[CSR_MBB]), 32'h0);
            end
        endcase
    endtask

    initial
    begin
        byte_t       v;
        logic [31:0] rnd;
        int          n;
        wr_ena    = 1'b0;
        wr_addr   = 5'd0;
        wr_data   = 8'h00;
        rd_ena    = 1'b0;
        rd_addr   = 5'd0;
        read_mode = 1'b0;
        void'($urandom(32'h2c25_4a1d));

        n = 0;
        while (!reset_n && n < 100)
        begin
            @(posedge sysclk);
            n++;
        end
        if (!reset_n)
            stop_run("reset was never released");

        reg_read(ADDR_SR, v);
        check_eq("sr after reset", 32'(v), 32'h81);
        reg_read(ADDR_DFSRR, v);
        check_eq("dfsrr after reset", 32'(v), 32'h10);
        write_readback(ADDR_FDR, 8'h2A, "fdr readback");
        write_readback(ADDR_CR, 8'h80, "cr readback");
        write_readback(ADDR_DFSRR, 8'h0C, "dfsrr readback");
        reg_write(ADDR_DFSRR, 8'h10);

        add_row(OP_START, 8'h00, 8'h00, 1'b0);
        add_row(OP_WRITE, 8'h00, 8'h3C, 1'b0);
        add_row(OP_WRITE, 8'h20, 8'hA5, 1'b0);
        rnd = $urandom();
        add_row(OP_WRITE, 8'h00, rnd[7:0], 1'b0);
        rnd = $urandom();
        add_row(OP_WRITE, 8'h20, rnd[7:0], 1'b0);
        add_row(OP_READ, 8'h00, 8'h00, 1'b0);
        add_row(OP_WRITE, 8'h20, 8'h5A, 1'b0);   // new byte so the next read differs
        add_row(OP_READ, 8'h20, 8'h00, 1'b1);
        add_row(OP_STOP, 8'h00, 8'h00, 1'b0);

        foreach (rows[i])
            apply_row(rows[i]);

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- vlog.f
hdl/i2c_pkg.sv
hdl/i2c_cmd_if.sv
hdl/i2c_regs.sv
hdl/i2c_cmd_seq.sv
hdl/i2c_rate_div.sv
hdl/i2c_byte_engine.sv
hdl/i2c_master_top.sv
testbench/tb_clkgen.sv
testbench/tb_i2c_slave.sv
testbench/tb_i2c_master.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module tb_i2c_master -o tb_i2c_master
	./obj_dir/tb_i2c_master

clean:
	rm -rf obj_dir
